//--- hw/adder_tree.sv
/*
 * pipelined per-column adder tree, bias add and saturation
 * into the result register on capture
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module adder_tree (
    input  logic             clk,
    input  logic             reset,
    input  dense_pkg::prod_t prod    [`DENSE_N_IN][`DENSE_N_OUT],
    input  logic             capture,
    output dense_pkg::data_t out_vec [`DENSE_N_OUT]
);
    import dense_pkg::*;

    localparam int   n_half  = `DENSE_N_IN / 2;
    localparam acc_t acc_max = (acc_t'(1) <<< (`DENSE_WIDTH - 1)) - acc_t'(1);
    localparam acc_t acc_min = -(acc_t'(1) <<< (`DENSE_WIDTH - 1));

    acc_t  leaf   [`DENSE_N_OUT][`DENSE_N_IN];
    // level s holds N_IN >> (s+1) partial sums per column
    acc_t  tree   [`DENSE_TREE_STAGES][`DENSE_N_OUT][n_half];
    acc_t  biased [`DENSE_N_OUT];
    data_t sat    [`DENSE_N_OUT];

    // sign extend products, transpose to column order
    always_comb begin
        for (int c = 0; c < `DENSE_N_OUT; c++) begin
            for (int i = 0; i < `DENSE_N_IN; i++) begin
                leaf[c][i] = prod[i][c];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tree <= '{default: '{default: '{default: '0}}};
        end else begin
            for (int c = 0; c < `DENSE_N_OUT; c++) begin
                for (int i = 0; i < n_half; i++) begin
                    tree[0][c][i] <= leaf[c][2*i] + leaf[c][2*i+1];
                end
                for (int s = 1; s < `DENSE_TREE_STAGES; s++) begin
                    for (int i = 0; i < (`DENSE_N_IN >> (s + 1)); i++) begin
                        tree[s][c][i] <= tree[s-1][c][2*i] + tree[s-1][c][2*i+1];
                    end
                end
            end
        end
    end

    // bias and clamp to data_t range
    always_comb begin
        for (int c = 0; c < `DENSE_N_OUT; c++) begin
            biased[c] = tree[`DENSE_TREE_STAGES-1][c][0] + BIAS[c];
            if (biased[c] > acc_max) begin
                sat[c] = data_t'(acc_max);
            end else if (biased[c] < acc_min) begin
                sat[c] = data_t'(acc_min);
            end else begin
                sat[c] = data_t'(biased[c]);
            end
        end
    end

    // results hold until the next capture
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_vec <= '{default: '0};
        end else if (capture) begin
            out_vec <= sat;
        end
    end

endmodule

//--- hw/dense_ctrl_fsm.sv
/*
 * dense layer control FSM, sequences a run from start
 * through capture to done
 */
`timescale 1ns/1ps

module dense_ctrl_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic cnt_zero,
    output logic cnt_load,
    output logic capture,
    output logic busy,
    output logic done
);
    import dense_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = RUN;
                end
            end
            // wait out the multiplier and tree stages
            RUN: begin
                if (cnt_zero) begin
                    state_next = CAPTURE;
                end
            end
            CAPTURE: state_next = DONE;
            // a new start clears done and begins the next run at once
            DONE: begin
                if (start) begin
                    state_next = RUN;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign cnt_load = start && ((state == IDLE) || (state == DONE));
    assign capture  = (state == CAPTURE);
    assign busy     = (state == RUN) || (state == CAPTURE);
    assign done     = (state == DONE);

endmodule

//--- hw/dense_cycle_counter.sv
/*
 * latency down-counter, flags zero once per armed load
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module dense_cycle_counter (
    input  logic clk,
    input  logic reset,
    input  logic cnt_load,
    output logic cnt_zero
);
    localparam int cnt_w = $clog2(`DENSE_LATENCY);

    logic [cnt_w-1:0] count;
    logic             armed;

    // multiplier stage and capture edge are not counted
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            armed <= 1'b0;
        end else if (cnt_load) begin
            count <= cnt_w'(`DENSE_LATENCY - 2);
            armed <= 1'b1;
        end else if (armed) begin
            if (count == '0) begin
                armed <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign cnt_zero = armed && (count == '0);

endmodule

//--- hw/dense_layer_top.sv
/*
 * dense layer top: Wishbone register slave, run control
 * and the multiply and adder tree datapath
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module dense_layer_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        irq
);
    import dense_pkg::*;

    data_t in_vec  [`DENSE_N_IN];
    data_t out_vec [`DENSE_N_OUT];
    prod_t prod    [`DENSE_N_IN][`DENSE_N_OUT];
    logic  start;
    logic  busy;
    logic  done;
    logic  cnt_load;
    logic  cnt_zero;
    logic  capture;

    // interrupt follows done, cleared by the next start
    assign irq = done;

    wb_dense_regs wb_dense_regs_i (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .busy, .done, .out_vec, .in_vec, .start
    );

    dense_ctrl_fsm dense_ctrl_fsm_i (
        .clk, .reset, .start, .cnt_zero, .cnt_load, .capture, .busy, .done
    );

    dense_cycle_counter dense_cycle_counter_i (.clk, .reset, .cnt_load, .cnt_zero);

    weight_mult_array weight_mult_array_i (.clk, .reset, .in_vec, .prod);

    adder_tree adder_tree_i (.clk, .reset, .prod, .capture, .out_vec);

endmodule

//--- hw/dense_pkg.sv
/*
 * dense layer types, control FSM states and the fixed
 * weight and bias tables (Q7.8)
 */
`include "dense_defines.svh"

package dense_pkg;

    typedef logic signed [`DENSE_WIDTH-1:0] data_t;
    // product after dropping the low fractional bits
    typedef logic signed [`DENSE_WIDTH-1:0] prod_t;
    // two guard bits for the column sum plus bias
    typedef logic signed [`DENSE_WIDTH+1:0] acc_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        CAPTURE,
        DONE
    } ctrl_state_t;

    // indexed [input][output], all magnitudes below 1.0
    localparam data_t WEIGHTS [`DENSE_N_IN][`DENSE_N_OUT] = '{
        '{16'sd192,  -16'sd128, 16'sd64,   16'sd230},
        '{-16'sd160, 16'sd200,  16'sd96,   -16'sd64},
        '{16'sd128,  16'sd32,   -16'sd224, 16'sd180},
        '{16'sd80,   -16'sd240, 16'sd150,  16'sd100}
    };

    localparam data_t BIAS [`DENSE_N_OUT] = '{16'sd64, -16'sd128, 16'sd256, -16'sd32};

endpackage

//--- hw/wb_dense_regs.sv
/*
 * Wishbone classic slave for the dense layer: input bank,
 * start control, status and result readback
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module wb_dense_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [3:0]          wb_adr,
    input  logic [31:0]         wb_dat_w,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack,
    input  logic                busy,
    input  logic                done,
    input  dense_pkg::data_t    out_vec [`DENSE_N_OUT],
    output dense_pkg::data_t    in_vec  [`DENSE_N_IN],
    output logic                start
);
    import dense_pkg::*;

    logic        req;
    logic        wr_req;
    logic [31:0] rd_data;

    // new access, not yet acked
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;

    // start pulse on the accepting edge, only when not busy
    assign start = wr_req && (wb_adr == `WB_ADDR_CTRL) && wb_dat_w[0] && !busy;

    // ack one cycle after the request, single cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // input bank, frozen for the whole run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_vec <= '{default: '0};
        end else if (wr_req && !busy) begin
            for (int i = 0; i < `DENSE_N_IN; i++) begin
                if (wb_adr == 4'(`WB_ADDR_IN0 + i)) begin
                    in_vec[i] <= data_t'(wb_dat_w[`DENSE_WIDTH-1:0]);
                end
            end
        end
    end

    // read mux, sign extended words
    always_comb begin
        rd_data = '0;
        if (wb_adr == `WB_ADDR_STATUS) begin
            rd_data = {30'd0, done, busy};
        end
        for (int i = 0; i < `DENSE_N_IN; i++) begin
            if (wb_adr == 4'(`WB_ADDR_IN0 + i)) begin
                rd_data = 32'(in_vec[i]);
            end
        end
        for (int j = 0; j < `DENSE_N_OUT; j++) begin
            if (wb_adr == 4'(`WB_ADDR_OUT0 + j)) begin
                rd_data = 32'(out_vec[j]);
            end
        end
    end

    // read data valid together with ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_dat_r <= '0;
        end else if (req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

//--- hw/weight_mult_array.sv
/*
 * constant-weight multiplier array, one registered stage,
 * keeps the top fractional bits of each product
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module weight_mult_array (
    input  logic             clk,
    input  logic             reset,
    input  dense_pkg::data_t in_vec [`DENSE_N_IN],
    output dense_pkg::prod_t prod   [`DENSE_N_IN][`DENSE_N_OUT]
);
    import dense_pkg::*;

    // full width product, double the fractional bits
    logic signed [2*`DENSE_WIDTH-1:0] full [`DENSE_N_IN][`DENSE_N_OUT];

    always_comb begin
        for (int i = 0; i < `DENSE_N_IN; i++) begin
            for (int o = 0; o < `DENSE_N_OUT; o++) begin
                full[i][o] = in_vec[i] * WEIGHTS[i][o];
            end
        end
    end

    // window [W+NF-1:NF] is the arithmetic shift, truncated to W bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod <= '{default: '{default: '0}};
        end else begin
            for (int i = 0; i < `DENSE_N_IN; i++) begin
                for (int o = 0; o < `DENSE_N_OUT; o++) begin
                    prod[i][o] <= full[i][o][`DENSE_WIDTH+`DENSE_NFRAC-1:`DENSE_NFRAC];
                end
            end
        end
    end

endmodule

//--- include/dense_defines.svh
/*
 * dense layer sizing, fixed-point format, Wishbone register map
 * and pipeline latency
 */
`ifndef DENSE_DEFINES_SVH
`define DENSE_DEFINES_SVH

// layer shape
`define DENSE_N_IN        4
`define DENSE_N_OUT       4

// Q7.8 signed fixed point
`define DENSE_WIDTH       16
`define DENSE_NFRAC       8

// log2 of DENSE_N_IN
`define DENSE_TREE_STAGES 2
// edges from start acceptance to done
`define DENSE_LATENCY     4

// word addresses
`define WB_ADDR_IN0       4'd0
`define WB_ADDR_CTRL      4'd4
`define WB_ADDR_STATUS    4'd5
`define WB_ADDR_OUT0      4'd8

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the dense layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module dense_layer_tb \
    -f sim.f -o dense_layer_sim > build.log 2>&1 \
    && ./obj_dir/dense_layer_sim +verilator+error+limit+1000 > sim.log 2>&1
cat build.log
cat sim.log 2>/dev/null
grep -q "tests failed" sim.log 2>/dev/null && exit 1
grep -q "all tests passed" sim.log 2>/dev/null || exit 1
exit 0

//--- sim.f
+incdir+include
hw/dense_pkg.sv
hw/wb_dense_regs.sv
hw/dense_ctrl_fsm.sv
hw/dense_cycle_counter.sv
hw/weight_mult_array.sv
hw/adder_tree.sv
hw/dense_layer_top.sv
sim/dense_layer_assertions.sv
sim/dense_layer_tb.sv

//--- sim/dense_layer_assertions.sv
/*
 * Wishbone handshake and run timing assertions, bound into
 * the dense layer top level
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module dense_layer_assertions (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic start,
    input logic busy,
    input logic done
);
    int assert_errors = 0;

    // ack lasts a single cycle
    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            assert_errors++;
            $error("wb_ack held for more than one cycle");
        end

    // one wait cycle, then ack
    ack_delay: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            assert_errors++;
            $error("wb_ack missing one cycle after the request");
        end

    // done set on edge DENSE_LATENCY, seen one sample later
    done_latency: assert property (@(posedge clk) disable iff (reset)
        start |=> ##(`DENSE_LATENCY) $rose(done))
        else begin
            assert_errors++;
            $error("done did not rise at the expected edge after start");
        end

    busy_done_excl: assert property (@(posedge clk) disable iff (reset) !(busy && done))
        else begin
            assert_errors++;
            $error("busy and done high together");
        end

endmodule

bind dense_layer_top dense_layer_assertions dense_layer_assertions_i (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_ack, .start, .busy, .done
);

//--- sim/dense_layer_tb.sv
/*
 * dense layer testbench: Wishbone host tasks, directed and random
 * vectors, fixed-point reference model and result readback
 */
`timescale 1ns/1ps
`include "dense_defines.svh"

module dense_layer_tb;
    import dense_pkg::*;

    localparam int clk_period = 40;
    localparam int n_tests    = 6;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        irq;

    integer      seed = 32'he3ac;
    int          check_errors;
    int          failing_tests;
    int          errors_at_start;
    logic [31:0] rdata;
    data_t       cur_vec [`DENSE_N_IN];

    dense_layer_top dense_layer_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 200 cycles per test
    initial begin
        #(n_tests * 200 * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", n_tests * 200);
        $display("tests failed");
        $finish;
    end

    // value checks plus bound assertion failures
    function automatic int error_total();
        return check_errors + dense_layer_top_i.dense_layer_assertions_i.assert_errors;
    endfunction

    // product shifted by NFRAC and cut to W bits, column sum plus bias, clamped
    function automatic data_t model_out(int o);
        int    sum;
        data_t p;
        sum = BIAS[o];
        for (int i = 0; i < `DENSE_N_IN; i++) begin
            p = data_t'((int'(cur_vec[i]) * int'(WEIGHTS[i][o])) >>> `DENSE_NFRAC);
            sum += p;
        end
        if (sum > (1 << (`DENSE_WIDTH - 1)) - 1) begin
            return data_t'((1 << (`DENSE_WIDTH - 1)) - 1);
        end else if (sum < -(1 << (`DENSE_WIDTH - 1))) begin
            return data_t'(-(1 << (`DENSE_WIDTH - 1)));
        end
        return data_t'(sum);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0d ns: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    // single classic cycle, starts and ends on a falling edge
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] data);
        int waits;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        waits    = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!wb_ack && waits < 8);
        if (!wb_ack) begin
            check_errors++;
            $display("no ack from the slave for address %0d", adr);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input logic [3:0] adr, input string name,
                              input logic [31:0] expected);
        wb_access(1'b0, adr, 32'd0);
        check_value(name, expected, rdata);
    endtask

    task automatic write_vector();
        for (int i = 0; i < `DENSE_N_IN; i++) begin
            wb_access(1'b1, 4'(`WB_ADDR_IN0 + i), {16'd0, cur_vec[i]});
        end
    endtask

    task automatic start_run();
        wb_access(1'b1, `WB_ADDR_CTRL, 32'd1);
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (!irq && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq) begin
            check_errors++;
            $display("irq did not rise within 20 cycles of the start");
        end
    endtask

    task automatic check_outputs();
        for (int o = 0; o < `DENSE_N_OUT; o++) begin
            read_check(4'(`WB_ADDR_OUT0 + o), $sformatf("out%0d", o), 32'(model_out(o)));
        end
    endtask

    task automatic run_vector();
        write_vector();
        start_run();
        wait_irq();
        check_outputs();
    endtask

    // roughly one value in four at full scale
    task automatic random_vector();
        int pick;
        for (int i = 0; i < `DENSE_N_IN; i++) begin
            pick = $random(seed) & 7;
            if (pick == 0) begin
                cur_vec[i] = 16'sh7fff;
            end else if (pick == 1) begin
                cur_vec[i] = 16'sh8000;
            end else begin
                cur_vec[i] = data_t'($random(seed));
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = error_total() - errors_at_start;
        if (errs != 0) begin
            failing_tests++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
        errors_at_start = error_total();
    endtask

    initial begin
        reset           = 1'b1;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        check_errors    = 0;
        failing_tests   = 0;
        errors_at_start = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        read_check(`WB_ADDR_STATUS, "status", 32'd0);
        for (int o = 0; o < `DENSE_N_OUT; o++) begin
            read_check(4'(`WB_ADDR_OUT0 + o), $sformatf("out%0d", o), 32'd0);
        end
        check_value("irq", 32'd0, 32'(irq));
        end_test(1, "reset state");

        // 1.5, -1.0, 0.25, -2.5
        cur_vec = '{16'sh0180, -16'sh0100, 16'sh0040, -16'sh0280};
        run_vector();
        end_test(2, "directed vector");

        // full scale, column 1 clamps low and column 3 high
        cur_vec = '{16'sh7fff, 16'sh8000, 16'sh7fff, 16'sh7fff};
        run_vector();
        repeat (20) begin
            random_vector();
            run_vector();
        end
        end_test(3, "random vectors with saturation");

        random_vector();
        run_vector();
        check_value("irq", 32'd1, 32'(irq));
        read_check(`WB_ADDR_STATUS, "status", 32'd2);
        random_vector();
        write_vector();
        start_run();
        check_value("irq", 32'd0, 32'(irq));
        // still in RUN, busy set and done cleared
        read_check(`WB_ADDR_STATUS, "status", 32'd1);
        wait_irq();
        read_check(`WB_ADDR_STATUS, "status", 32'd2);
        end_test(4, "irq and done bit");

        random_vector();
        write_vector();
        start_run();
        // input write and start request both land in RUN or CAPTURE
        wb_access(1'b1, `WB_ADDR_IN0, 32'h0000_1234);
        wb_access(1'b1, `WB_ADDR_CTRL, 32'd1);
        wait_irq();
        check_outputs();
        read_check(`WB_ADDR_IN0, "in0", 32'(cur_vec[0]));
        end_test(5, "writes while busy");

        // previous run never read back
        repeat (2) begin
            random_vector();
            write_vector();
            start_run();
            wait_irq();
            random_vector();
            run_vector();
        end
        end_test(6, "back-to-back runs");

        repeat (4) @(negedge clk);
        $display("%0d tests run, %0d failing, %0d check errors, %0d assertion errors",
                 n_tests, failing_tests, check_errors,
                 dense_layer_top_i.dense_layer_assertions_i.assert_errors);
        if (failing_tests == 0 && error_total() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
